//--- logic/usb_rx_pkg.sv
package usb_rx_pkg;

    // bus timing, full speed at eight clocks per bit
    localparam int clks_per_bit = 8;
    localparam int sample_offset = 4;

    // sync pattern as it lands in the shift window
    localparam logic [7:0] sync_byte = 8'h80;

    localparam logic [6:0] dev_addr = 7'h70;
    localparam logic [3:0] dev_endp = 4'h4;

    // payload buffer
    localparam int buf_depth = 8;
    localparam int buf_ptr_bits = 3;

    typedef enum logic [3:0] {
        pid_out   = 4'b0001,
        pid_in    = 4'b1001,
        pid_data0 = 4'b0011,
        pid_data1 = 4'b1011,
        pid_ack   = 4'b0010,
        pid_nak   = 4'b1010,
        pid_stall = 4'b1110
    } pid_t;

    typedef enum logic [2:0] {
        pkt_idle        = 3'd0,
        pkt_in          = 3'd1,
        pkt_out         = 3'd2,
        pkt_data        = 3'd3,
        pkt_ack         = 3'd4,
        pkt_nak         = 3'd5,
        pkt_unsupported = 3'd6,
        pkt_stall       = 3'd7
    } rx_packet_t;

    typedef enum logic [3:0] {
        st_idle,
        st_sync,
        st_pid,
        st_token_lo,
        st_token_hi,
        st_data_first,
        st_data_second,
        st_data_run,
        st_error,
        st_wait_eop,
        st_wait_idle,
        st_done
    } rcu_state_t;

endpackage

//--- logic/usb_rx_line_sync.sv
`timescale 1ns/1ps

module usb_rx_line_sync (
    input  logic clk,
    input  logic n_rst,
    input  logic d_plus,
    input  logic d_minus,
    output logic dp_sync,
    output logic dm_sync,
    output logic line_idle,
    output logic sop_edge,
    output logic se0
);

    logic dp_meta;
    logic dm_meta;
    logic idle_q;
    // set from start of packet until se0 seen
    logic busy;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_meta <= 1'b1;
            dp_sync <= 1'b1;
            dm_meta <= 1'b0;
            dm_sync <= 1'b0;
            idle_q  <= 1'b0;
            busy    <= 1'b0;
        end else begin
            dp_meta <= d_plus;
            dp_sync <= dp_meta;
            dm_meta <= d_minus;
            dm_sync <= dm_meta;
            idle_q  <= line_idle;
            if (sop_edge) begin
                busy <= 1'b1;
            end else if (se0) begin
                busy <= 1'b0;
            end
        end
    end

    assign line_idle = dp_sync && !dm_sync;
    assign se0 = !dp_sync && !dm_sync;

    // J to K after idle, only once per packet
    assign sop_edge = idle_q && !dp_sync && dm_sync && !busy;

endmodule

//--- logic/usb_bit_timer.sv
`timescale 1ns/1ps

module usb_bit_timer
    import usb_rx_pkg::*;
(
    input  logic clk,
    input  logic n_rst,
    input  logic sop_edge,
    input  logic timer_clear,
    input  logic se0,
    output logic shift_en,
    output logic byte_done,
    output logic byte_aligned,
    output logic eop
);

    typedef logic [$clog2(clks_per_bit)-1:0] cnt_t;

    logic running;
    cnt_t clk_cnt;
    logic [2:0] bit_cnt;

    // strobe when the down counter hits zero
    assign shift_en = running && (clk_cnt == '0);
    assign byte_aligned = (bit_cnt == 3'd0);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            running   <= 1'b0;
            clk_cnt   <= '0;
            bit_cnt   <= 3'd0;
            byte_done <= 1'b0;
            eop       <= 1'b0;
        end else begin
            byte_done <= shift_en && !se0 && (bit_cnt == 3'd7) && !sop_edge && !timer_clear;
            if (sop_edge) begin
                // first strobe lands mid-bit
                running <= 1'b1;
                clk_cnt <= cnt_t'(sample_offset - 1);
                bit_cnt <= 3'd0;
                eop     <= 1'b0;
            end else if (timer_clear) begin
                running <= 1'b0;
                clk_cnt <= '0;
                bit_cnt <= 3'd0;
                eop     <= 1'b0;
            end else if (running) begin
                if (clk_cnt == '0) begin
                    clk_cnt <= cnt_t'(clks_per_bit - 1);
                    eop     <= se0;
                    // se0 bits are not data, keep the byte count
                    if (!se0) begin
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt - cnt_t'(1);
                end
            end
        end
    end

endmodule

//--- logic/usb_nrzi_shifter.sv
`timescale 1ns/1ps

module usb_nrzi_shifter (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        sop_edge,
    input  logic        shift_en,
    input  logic        dp_sync,
    output logic [23:0] rcv_data
);

    logic prev_level;
    logic bit_val;

    // no transition means a one
    assign bit_val = (dp_sync == prev_level);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            prev_level <= 1'b1;
        end else if (sop_edge) begin
            // line was in J before the packet
            prev_level <= 1'b1;
        end else if (shift_en) begin
            prev_level <= dp_sync;
        end
    end

    // lsb first, newest bit enters at the top
    always_ff @(posedge clk) begin
        if (shift_en && !sop_edge) begin
            rcv_data <= {bit_val, rcv_data[23:1]};
        end
    end

endmodule

//--- logic/usb_rx_rcu.sv
`timescale 1ns/1ps

module usb_rx_rcu
    import usb_rx_pkg::*;
(
    input  logic        clk,
    input  logic        n_rst,
    input  logic        byte_done,
    input  logic        byte_aligned,
    input  logic        eop,
    input  logic        line_idle,
    input  logic        sop_edge,
    input  logic [23:0] rcv_data,
    output logic        receiving,
    output rx_packet_t  rx_packet,
    output logic        r_error,
    output logic        packet_done,
    output logic        buf_write,
    output logic        timer_clear
);

    rcu_state_t state;
    rcu_state_t next_state;
    rx_packet_t next_rx_packet;
    pid_t pid;
    logic pid_ok;
    logic token_match;
    logic done_hold;

    // pid byte sits in the newest slot right after byte_done
    assign pid = pid_t'(rcv_data[19:16]);
    assign pid_ok = (rcv_data[23:20] == ~rcv_data[19:16]);

    // addr in low byte, endpoint straddles both
    assign token_match = (rcv_data[14:8] == dev_addr) && (rcv_data[18:15] == dev_endp);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state       <= st_idle;
            rx_packet   <= pkt_idle;
            r_error     <= 1'b0;
            done_hold   <= 1'b0;
            packet_done <= 1'b0;
        end else begin
            state       <= next_state;
            rx_packet   <= next_rx_packet;
            r_error     <= (state == st_error);
            done_hold   <= (state == st_done);
            packet_done <= (state == st_done) && !done_hold;
        end
    end

    always_comb begin
        next_state = state;
        next_rx_packet = rx_packet;
        case (state)
            st_idle: begin
                if (sop_edge) begin
                    next_state = st_sync;
                    next_rx_packet = pkt_idle;
                end
            end
            st_sync: begin
                if (eop) begin
                    next_state = st_error;
                end else if (byte_done) begin
                    next_state = (rcv_data[23:16] == sync_byte) ? st_pid : st_error;
                end
            end
            st_pid: begin
                if (eop) begin
                    next_state = st_error;
                end else if (byte_done) begin
                    if (!pid_ok) begin
                        next_state = st_error;
                    end else begin
                        case (pid)
                            pid_out: begin
                                next_state = st_token_lo;
                                next_rx_packet = pkt_out;
                            end
                            pid_in: begin
                                next_state = st_token_lo;
                                next_rx_packet = pkt_in;
                            end
                            pid_data0, pid_data1: begin
                                next_state = st_data_first;
                                next_rx_packet = pkt_data;
                            end
                            pid_ack: begin
                                next_state = st_wait_eop;
                                next_rx_packet = pkt_ack;
                            end
                            pid_nak: begin
                                next_state = st_wait_eop;
                                next_rx_packet = pkt_nak;
                            end
                            pid_stall: begin
                                next_state = st_error;
                                next_rx_packet = pkt_stall;
                            end
                            default: begin
                                next_state = st_wait_eop;
                                next_rx_packet = pkt_unsupported;
                            end
                        endcase
                    end
                end
            end
            st_token_lo: begin
                if (eop) begin
                    next_state = st_error;
                end else if (byte_done) begin
                    next_state = st_token_hi;
                end
            end
            st_token_hi: begin
                if (eop) begin
                    next_state = st_error;
                end else if (byte_done) begin
                    next_state = token_match ? st_done : st_wait_eop;
                end
            end
            st_data_first: begin
                if (eop) begin
                    next_state = st_error;
                end else if (byte_done) begin
                    next_state = st_data_second;
                end
            end
            st_data_second: begin
                if (eop) begin
                    next_state = st_error;
                end else if (byte_done) begin
                    next_state = st_data_run;
                end
            end
            st_data_run: begin
                // the last two bytes held back are the crc16
                if (eop) begin
                    next_state = (byte_aligned && !byte_done) ? st_done : st_error;
                end
            end
            st_error: begin
                if (eop && line_idle) begin
                    next_state = st_idle;
                end
            end
            st_wait_eop: begin
                if (eop) begin
                    next_state = st_wait_idle;
                end
            end
            st_wait_idle, st_done: begin
                if (line_idle) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    assign receiving = (state == st_sync) || (state == st_pid) ||
                       (state == st_token_lo) || (state == st_token_hi) ||
                       (state == st_data_first) || (state == st_data_second) ||
                       (state == st_data_run) || (state == st_wait_eop);

    // byte two slots back is payload once two more arrived
    assign buf_write = (state == st_data_run) && byte_done && !eop;
    assign timer_clear = (state == st_done);

endmodule

//--- logic/usb_rx_buffer.sv
`timescale 1ns/1ps

module usb_rx_buffer
    import usb_rx_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       sop_edge,
    input  logic       buf_write,
    input  logic [7:0] wdata,
    input  logic       rx_read,
    output logic [7:0] rx_data,
    output logic       rx_empty,
    output logic       rx_overflow
);

    logic [7:0] mem [buf_depth];
    // extra msb tells full from empty
    logic [buf_ptr_bits:0] wptr;
    logic [buf_ptr_bits:0] rptr;
    logic full;

    assign full = (wptr[buf_ptr_bits] != rptr[buf_ptr_bits]) &&
                  (wptr[buf_ptr_bits-1:0] == rptr[buf_ptr_bits-1:0]);
    assign rx_empty = (wptr == rptr);
    assign rx_data = mem[rptr[buf_ptr_bits-1:0]];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wptr        <= '0;
            rptr        <= '0;
            rx_overflow <= 1'b0;
        end else begin
            if (buf_write && !full) begin
                wptr <= wptr + 1'b1;
            end
            if (rx_read && !rx_empty) begin
                rptr <= rptr + 1'b1;
            end
            // sticky until the next packet starts
            if (sop_edge) begin
                rx_overflow <= 1'b0;
            end else if (buf_write && full) begin
                rx_overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_write && !full) begin
            mem[wptr[buf_ptr_bits-1:0]] <= wdata;
        end
    end

endmodule

//--- logic/usb_rx_top.sv
`timescale 1ns/1ps

module usb_rx_top
    import usb_rx_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       d_plus,
    input  logic       d_minus,
    input  logic       rx_read,
    output logic       receiving,
    output rx_packet_t rx_packet,
    output logic       r_error,
    output logic       packet_done,
    output logic [7:0] rx_data,
    output logic       rx_empty,
    output logic       rx_overflow
);

    logic        dp_sync;
    logic        line_idle;
    logic        sop_edge;
    logic        se0;
    logic        shift_en;
    logic        byte_done;
    logic        byte_aligned;
    logic        eop;
    logic        timer_clear;
    logic        buf_write;
    logic [23:0] rcv_data;

    // dm_sync only feeds the line decode inside
    usb_rx_line_sync u_line_sync (
        .clk       (clk),
        .n_rst     (n_rst),
        .d_plus    (d_plus),
        .d_minus   (d_minus),
        .dp_sync   (dp_sync),
        .dm_sync   (),
        .line_idle (line_idle),
        .sop_edge  (sop_edge),
        .se0       (se0)
    );

    usb_bit_timer u_bit_timer (
        .clk          (clk),
        .n_rst        (n_rst),
        .sop_edge     (sop_edge),
        .timer_clear  (timer_clear),
        .se0          (se0),
        .shift_en     (shift_en),
        .byte_done    (byte_done),
        .byte_aligned (byte_aligned),
        .eop          (eop)
    );

    usb_nrzi_shifter u_shifter (
        .clk      (clk),
        .n_rst    (n_rst),
        .sop_edge (sop_edge),
        .shift_en (shift_en),
        .dp_sync  (dp_sync),
        .rcv_data (rcv_data)
    );

    usb_rx_rcu u_rcu (
        .clk          (clk),
        .n_rst        (n_rst),
        .byte_done    (byte_done),
        .byte_aligned (byte_aligned),
        .eop          (eop),
        .line_idle    (line_idle),
        .sop_edge     (sop_edge),
        .rcv_data     (rcv_data),
        .receiving    (receiving),
        .rx_packet    (rx_packet),
        .r_error      (r_error),
        .packet_done  (packet_done),
        .buf_write    (buf_write),
        .timer_clear  (timer_clear)
    );

    usb_rx_buffer u_buffer (
        .clk         (clk),
        .n_rst       (n_rst),
        .sop_edge    (sop_edge),
        .buf_write   (buf_write),
        .wdata       (rcv_data[7:0]),
        .rx_read     (rx_read),
        .rx_data     (rx_data),
        .rx_empty    (rx_empty),
        .rx_overflow (rx_overflow)
    );

endmodule

//--- test/usb_rx_assertions.sv
`timescale 1ns/1ps

module usb_rx_assertions
    import usb_rx_pkg::*;
(
    input logic       clk,
    input logic       n_rst,
    input rcu_state_t state,
    input logic       sop_edge,
    input logic       packet_done,
    input logic       buf_write,
    input logic       r_error
);

    // what the current packet has produced so far
    logic done_in_pkt;
    logic err_in_pkt;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            done_in_pkt <= 1'b0;
            err_in_pkt  <= 1'b0;
        end else if (sop_edge) begin
            done_in_pkt <= 1'b0;
            err_in_pkt  <= 1'b0;
        end else begin
            if (packet_done) begin
                done_in_pkt <= 1'b1;
            end
            if (r_error) begin
                err_in_pkt <= 1'b1;
            end
        end
    end

    // one single-cycle pulse per packet
    done_one_cycle: assert property (@(posedge clk) disable iff (!n_rst)
        packet_done |-> !done_in_pkt)
        else $error("packet_done pulsed again within the same packet");

    // the strobe that enters the run would store the pid
    write_in_run: assert property (@(posedge clk) disable iff (!n_rst)
        buf_write |-> ($past(state) == st_data_run))
        else $error("buf_write outside st_data_run");

    no_error_with_done: assert property (@(posedge clk) disable iff (!n_rst)
        packet_done |-> (!r_error && !err_in_pkt))
        else $error("packet_done in a packet that raised r_error");

endmodule

bind usb_rx_rcu usb_rx_assertions u_assertions (
    .clk         (clk),
    .n_rst       (n_rst),
    .state       (state),
    .sop_edge    (sop_edge),
    .packet_done (packet_done),
    .buf_write   (buf_write),
    .r_error     (r_error)
);

//--- test/usb_rx_checker.sv
`timescale 1ns/1ps

module usb_rx_checker
    import usb_rx_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       receiving,
    input  logic       packet_done,
    input  logic       r_error,
    input  rx_packet_t rx_packet,
    input  logic       rx_overflow,
    input  logic       rx_empty,
    input  logic [7:0] rx_data,
    output logic       rx_read,
    input  logic       check_req,
    input  rx_packet_t exp_kind,
    input  int         exp_err,
    input  int         exp_done,
    input  int         exp_count,
    input  int         exp_ovf,
    input  logic [7:0] exp_bytes [16],
    output logic       check_ack,
    output int         error_count,
    output int         check_count
);

    logic read_q = 1'b0;
    logic ack_q = 1'b0;
    logic err_q = 1'b0;
    logic recv_q = 1'b0;
    logic draining = 1'b0;
    int done_seen = 0;
    int err_seen = 0;
    int recv_seen = 0;
    int idx = 0;
    int errs = 0;
    int checks = 0;

    assign rx_read = read_q;
    assign check_ack = ack_q;
    assign error_count = errs;
    assign check_count = checks;

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errs++;
            $display("[FAIL] %s expected 0x%02h got 0x%02h", name, exp, act);
        end
    endtask

    task automatic check_events(input string what, input int exp, input int seen);
        checks++;
        if (exp != seen) begin
            errs++;
            $display("expected %0d %s in the packet but saw %0d", exp, what, seen);
        end
    endtask

    always @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            read_q <= 1'b0;
            ack_q <= 1'b0;
            err_q <= 1'b0;
            recv_q <= 1'b0;
            draining <= 1'b0;
            done_seen <= 0;
            err_seen <= 0;
            recv_seen <= 0;
        end else begin
            read_q <= 1'b0;
            ack_q <= 1'b0;
            err_q <= r_error;
            recv_q <= receiving;
            if (packet_done) begin
                done_seen <= done_seen + 1;
            end
            if (r_error && !err_q) begin
                err_seen <= err_seen + 1;
            end
            // every packet opens exactly one receive window
            if (receiving && !recv_q) begin
                recv_seen <= recv_seen + 1;
            end
            if (check_req && !draining) begin
                check_value("rx_packet", 8'(exp_kind), 8'(rx_packet));
                check_value("rx_overflow", 8'(exp_ovf), 8'(rx_overflow));
                check_value("receiving", 8'h00, 8'(receiving));
                check_events("packet_done pulses", exp_done, done_seen);
                check_events("r_error rises", exp_err, err_seen);
                check_events("receiving rises", 1, recv_seen);
                draining <= 1'b1;
                idx <= 0;
            end else if (draining && !read_q) begin
                if (!rx_empty) begin
                    if (idx < exp_count) begin
                        check_value("rx_data", exp_bytes[idx[3:0]], rx_data);
                    end else begin
                        errs++;
                        $display("extra byte 0x%02h in buffer beyond %0d expected",
                                 rx_data, exp_count);
                    end
                    read_q <= 1'b1;
                    idx <= idx + 1;
                end else begin
                    // buffer drained, packet closed
                    if (idx < exp_count) begin
                        errs++;
                        $display("buffer ran empty after %0d of %0d bytes", idx, exp_count);
                    end
                    draining <= 1'b0;
                    ack_q <= 1'b1;
                    done_seen <= 0;
                    err_seen <= 0;
                    recv_seen <= 0;
                end
            end
        end
    end

endmodule

//--- test/tb_usb_rx.sv
`timescale 1ns/1ps

module tb_usb_rx
    import usb_rx_pkg::*;
;

    logic clk;
    logic n_rst;
    logic d_plus;
    logic d_minus;
    logic rx_read;
    logic receiving;
    rx_packet_t rx_packet;
    logic r_error;
    logic packet_done;
    logic [7:0] rx_data;
    logic rx_empty;
    logic rx_overflow;

    logic check_req;
    logic check_ack;
    rx_packet_t exp_kind;
    int exp_err;
    int exp_done;
    int exp_count;
    int exp_ovf;
    logic [7:0] cur_bytes [16];
    int error_count;
    int check_count;

    // packet table
    logic [7:0] sync_tab [24];
    logic [7:0] pid_tab [24];
    int tok_tab [24];
    logic [6:0] addr_tab [24];
    logic [3:0] endp_tab [24];
    int npay_tab [24];
    int ncrc_tab [24];
    int extra_tab [24];
    rx_packet_t kind_tab [24];
    int err_tab [24];
    int done_tab [24];
    int stored_tab [24];
    int ovf_tab [24];
    logic [7:0] pay_tab [24][16];
    int n_pkts = 0;

    logic [31:0] lfsr_state = 32'h506a_59b0;
    logic level;
    logic table_ready = 1'b0;

    usb_rx_top dut (
        .clk         (clk),
        .n_rst       (n_rst),
        .d_plus      (d_plus),
        .d_minus     (d_minus),
        .rx_read     (rx_read),
        .receiving   (receiving),
        .rx_packet   (rx_packet),
        .r_error     (r_error),
        .packet_done (packet_done),
        .rx_data     (rx_data),
        .rx_empty    (rx_empty),
        .rx_overflow (rx_overflow)
    );

    usb_rx_checker u_checker (
        .clk         (clk),
        .n_rst       (n_rst),
        .receiving   (receiving),
        .packet_done (packet_done),
        .r_error     (r_error),
        .rx_packet   (rx_packet),
        .rx_overflow (rx_overflow),
        .rx_empty    (rx_empty),
        .rx_data     (rx_data),
        .rx_read     (rx_read),
        .check_req   (check_req),
        .exp_kind    (exp_kind),
        .exp_err     (exp_err),
        .exp_done    (exp_done),
        .exp_count   (exp_count),
        .exp_ovf     (exp_ovf),
        .exp_bytes   (cur_bytes),
        .check_ack   (check_ack),
        .error_count (error_count),
        .check_count (check_count)
    );

    always #2 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_payload_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
        // keeps every run of ones short
        b[2] = 1'b0;
        b[6] = 1'b0;
    endtask

    task automatic add_entry(input logic [7:0] sync, input logic [7:0] pid, input int tok,
                             input logic [6:0] addr, input logic [3:0] endp, input int npay,
                             input int ncrc, input int extra, input rx_packet_t kind,
                             input int err, input int done, input int stored, input int ovf);
        int i;
        sync_tab[n_pkts] = sync;
        pid_tab[n_pkts] = pid;
        tok_tab[n_pkts] = tok;
        addr_tab[n_pkts] = addr;
        endp_tab[n_pkts] = endp;
        npay_tab[n_pkts] = npay;
        ncrc_tab[n_pkts] = ncrc;
        extra_tab[n_pkts] = extra;
        kind_tab[n_pkts] = kind;
        err_tab[n_pkts] = err;
        done_tab[n_pkts] = done;
        stored_tab[n_pkts] = stored;
        ovf_tab[n_pkts] = ovf;
        for (i = 0; i < 16; i++) begin
            pay_tab[n_pkts][i] = 8'h00;
        end
        for (i = 0; i < npay; i++) begin
            random_payload_byte(pay_tab[n_pkts][i]);
        end
        n_pkts++;
    endtask

    task automatic fill_table();
        //        sync   pid    tok addr   endp pay crc ext kind     err done st ovf
        add_entry(8'h80, 8'hE1, 1, 7'h70, 4'h4, 0, 0, 0, pkt_out, 0, 1, 0, 0);
        add_entry(8'h80, 8'h69, 1, 7'h70, 4'h4, 0, 0, 0, pkt_in, 0, 1, 0, 0);
        add_entry(8'h80, 8'hE1, 1, 7'h15, 4'h4, 0, 0, 0, pkt_out, 0, 0, 0, 0);
        add_entry(8'h80, 8'hC3, 0, 7'h00, 4'h0, 3, 2, 0, pkt_data, 0, 1, 3, 0);
        add_entry(8'h80, 8'h4B, 0, 7'h00, 4'h0, 6, 2, 0, pkt_data, 0, 1, 6, 0);
        add_entry(8'h80, 8'hC3, 0, 7'h00, 4'h0, 1, 2, 0, pkt_data, 0, 1, 1, 0);
        add_entry(8'h80, 8'hD2, 0, 7'h00, 4'h0, 0, 0, 0, pkt_ack, 0, 0, 0, 0);
        add_entry(8'h80, 8'h5A, 0, 7'h00, 4'h0, 0, 0, 0, pkt_nak, 0, 0, 0, 0);
        add_entry(8'h80, 8'h96, 0, 7'h00, 4'h0, 0, 0, 0, pkt_unsupported, 0, 0, 0, 0);
        // bad sync, bad pid check, stall
        add_entry(8'h40, 8'hD2, 0, 7'h00, 4'h0, 0, 0, 0, pkt_idle, 1, 0, 0, 0);
        add_entry(8'h80, 8'hA1, 0, 7'h00, 4'h0, 0, 0, 0, pkt_idle, 1, 0, 0, 0);
        add_entry(8'h80, 8'h1E, 0, 7'h00, 4'h0, 0, 0, 0, pkt_stall, 1, 0, 0, 0);
        add_entry(8'h80, 8'h69, 1, 7'h70, 4'h4, 0, 0, 0, pkt_in, 0, 1, 0, 0);
        // cut after one byte, then cut mid-byte
        add_entry(8'h80, 8'hC3, 0, 7'h00, 4'h0, 1, 0, 0, pkt_data, 1, 0, 0, 0);
        add_entry(8'h80, 8'h4B, 0, 7'h00, 4'h0, 3, 0, 4, pkt_data, 1, 0, 1, 0);
        add_entry(8'h80, 8'hC3, 0, 7'h00, 4'h0, 4, 2, 0, pkt_data, 0, 1, 4, 0);
        add_entry(8'h80, 8'h4B, 0, 7'h00, 4'h0, 10, 2, 0, pkt_data, 0, 1, 8, 1);
        add_entry(8'h80, 8'hE1, 1, 7'h70, 4'h4, 0, 0, 0, pkt_out, 0, 1, 0, 0);
    endtask

    function automatic int watchdog_cycles();
        int p;
        int bits;
        bits = 0;
        for (p = 0; p < n_pkts; p++) begin
            bits += 22 + 16 * tok_tab[p] + 8 * (npay_tab[p] + ncrc_tab[p]) + extra_tab[p];
        end
        return bits * clks_per_bit * 4;
    endfunction

    task automatic drive_bit_time(input logic dp, input logic dm);
        @(posedge clk);
        d_plus <= dp;
        d_minus <= dm;
        repeat (clks_per_bit - 1) @(posedge clk);
    endtask

    // nrzi, a zero toggles the line
    task automatic send_bit(input logic b);
        if (!b) begin
            level = ~level;
        end
        drive_bit_time(level, ~level);
    endtask

    task automatic send_byte(input logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++) begin
            send_bit(b[i]);
        end
    endtask

    task automatic send_packet(input int p);
        logic [7:0] tok_lo;
        logic [7:0] tok_hi;
        int i;
        level = 1'b1;
        send_byte(sync_tab[p]);
        send_byte(pid_tab[p]);
        if (tok_tab[p] != 0) begin
            // 7 bit addr then 4 bit endpoint, crc5 left as zeros
            tok_lo = {endp_tab[p][0], addr_tab[p]};
            tok_hi = {5'b00000, endp_tab[p][3:1]};
            send_byte(tok_lo);
            send_byte(tok_hi);
        end
        for (i = 0; i < npay_tab[p]; i++) begin
            send_byte(pay_tab[p][i]);
        end
        for (i = 0; i < ncrc_tab[p]; i++) begin
            send_byte(8'h00);
        end
        for (i = 0; i < extra_tab[p]; i++) begin
            send_bit(1'b0);
        end
        repeat (2) drive_bit_time(1'b0, 1'b0);
        repeat (4) drive_bit_time(1'b1, 1'b0);
    endtask

    task automatic request_check(input int p);
        int i;
        @(posedge clk);
        exp_kind <= kind_tab[p];
        exp_err <= err_tab[p];
        exp_done <= done_tab[p];
        exp_count <= stored_tab[p];
        exp_ovf <= ovf_tab[p];
        for (i = 0; i < 16; i++) begin
            cur_bytes[i] <= pay_tab[p][i];
        end
        check_req <= 1'b1;
        @(posedge clk);
        check_req <= 1'b0;
        while (!check_ack) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        n_rst = 1'b0;
        d_plus = 1'b1;
        d_minus = 1'b0;
        check_req = 1'b0;
        exp_kind = pkt_idle;
        exp_err = 0;
        exp_done = 0;
        exp_count = 0;
        exp_ovf = 0;
        for (int i = 0; i < 16; i++) begin
            cur_bytes[i] = 8'h00;
        end
        level = 1'b1;
        fill_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        repeat (4) @(posedge clk);
        for (int p = 0; p < n_pkts; p++) begin
            send_packet(p);
            request_check(p);
        end
        $display("packets %0d checks %0d errors %0d", n_pkts, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles()) @(posedge clk);
        $display("timeout, packets did not complete within %0d cycles", watchdog_cycles());
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src.f
logic/usb_rx_pkg.sv
logic/usb_rx_line_sync.sv
logic/usb_bit_timer.sv
logic/usb_nrzi_shifter.sv
logic/usb_rx_rcu.sv
logic/usb_rx_buffer.sv
logic/usb_rx_top.sv
test/usb_rx_assertions.sv
test/usb_rx_checker.sv
test/tb_usb_rx.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_usb_rx
FILELIST  := src.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
